//--- logic/video_pkg.sv
`default_nettype none

package video_pkg;

    // --------------------------------------------------
    // basic types
    // --------------------------------------------------

    // raster and viewport coordinates
    typedef logic [9:0]  pos_t;
    typedef logic [15:0] word_t;
    // byte address into video memory
    typedef logic [15:0] addr_t;
    // red in [11:8], green in [7:4], blue in [3:0]
    typedef logic [11:0] rgb444_t;
    typedef logic [23:0] rgb888_t;
    typedef logic [1:0]  mode_t;
    typedef logic [3:0]  pix_index_t;
    typedef logic [5:0]  reg_addr_t;

    // bits per pixel, 0 behaves as 1bpp
    localparam mode_t mode_1bpp = 2'd1;
    localparam mode_t mode_2bpp = 2'd2;
    localparam mode_t mode_4bpp = 2'd3;

    // --------------------------------------------------
    // register map, word addresses
    // --------------------------------------------------

    localparam reg_addr_t ctl_base      = 6'h00;
    localparam reg_addr_t ctl_left      = 6'h01;
    localparam reg_addr_t ctl_right     = 6'h02;
    localparam reg_addr_t ctl_top       = 6'h03;
    localparam reg_addr_t ctl_bottom    = 6'h04;
    localparam reg_addr_t ctl_mode      = 6'h05;
    localparam reg_addr_t ctl_border    = 6'h06;
    localparam reg_addr_t palette_first = 6'h10;

    localparam int palette_entries = 16;

    // raster position to pixel colour, inside the datapath
    localparam int pixel_latency = 2;

endpackage

`default_nettype wire

//--- logic/video_regs.sv
`default_nettype none
`timescale 1ns/100ps

module video_regs (
    input  logic                  clk_pixel,
    input  logic                  nreset,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  video_pkg::reg_addr_t  paddr,
    input  video_pkg::word_t      pwdata,
    input  video_pkg::pix_index_t palette_addr,
    output video_pkg::word_t      prdata,
    output logic                  pready,
    output logic                  pslverr,
    output video_pkg::addr_t      base_addr,
    output video_pkg::pos_t       vp_left,
    output video_pkg::pos_t       vp_right,
    output video_pkg::pos_t       vp_top,
    output video_pkg::pos_t       vp_bottom,
    output video_pkg::mode_t      mode,
    output video_pkg::rgb444_t    border,
    output video_pkg::rgb444_t    palette_data
);
    import video_pkg::*;

    rgb444_t palette [palette_entries];
    logic    access;
    logic    is_palette;
    logic    mapped;
    logic    wr_en;

    // --------------------------------------------------
    // apb decode, no wait states
    // --------------------------------------------------

    assign access     = psel && penable;
    assign is_palette = (paddr[5:4] == palette_first[5:4]);
    assign mapped     = is_palette || (paddr <= ctl_border);
    assign wr_en      = access && pwrite && mapped;

    assign pready  = access;
    assign pslverr = access && !mapped;

    always_ff @(posedge clk_pixel) begin
        if (!nreset) begin
            base_addr <= '0;
            vp_left   <= '0;
            vp_right  <= '0;
            vp_top    <= '0;
            vp_bottom <= '0;
            mode      <= '0;
            border    <= '0;
            for (int i = 0; i < palette_entries; i++) begin
                palette[i] <= '0;
            end
        end else if (wr_en) begin
            if (is_palette) begin
                palette[paddr[3:0]] <= pwdata[11:0];
            end else begin
                case (paddr)
                    ctl_base:   base_addr <= pwdata;
                    ctl_left:   vp_left   <= pwdata[9:0];
                    ctl_right:  vp_right  <= pwdata[9:0];
                    ctl_top:    vp_top    <= pwdata[9:0];
                    ctl_bottom: vp_bottom <= pwdata[9:0];
                    ctl_mode:   mode      <= pwdata[1:0];
                    ctl_border: border    <= pwdata[11:0];
                    default: ;
                endcase
            end
        end
    end

    // read back, unused bits read as zero
    always_comb begin
        prdata = '0;
        if (is_palette) begin
            prdata = {4'b0, palette[paddr[3:0]]};
        end else begin
            case (paddr)
                ctl_base:   prdata = base_addr;
                ctl_left:   prdata = {6'b0, vp_left};
                ctl_right:  prdata = {6'b0, vp_right};
                ctl_top:    prdata = {6'b0, vp_top};
                ctl_bottom: prdata = {6'b0, vp_bottom};
                ctl_mode:   prdata = {14'b0, mode};
                ctl_border: prdata = {4'b0, border};
                default:    prdata = '0;
            endcase
        end
    end

    // lookup port for the colour stage
    assign palette_data = palette[palette_addr];

endmodule

`default_nettype wire

//--- logic/raster_timing.sv
`default_nettype none
`timescale 1ns/100ps

module raster_timing #(
    parameter int h_back    = 44,
    parameter int h_visible = 640,
    parameter int h_front   = 16,
    parameter int h_sync    = 96,
    parameter int v_back    = 31,
    parameter int v_visible = 480,
    parameter int v_front   = 10,
    parameter int v_sync    = 2
) (
    input  logic            clk_pixel,
    input  logic            nreset,
    output video_pkg::pos_t h_pos,
    output video_pkg::pos_t v_pos,
    output logic            hsync_raw,
    output logic            vsync_raw,
    output logic            visible_raw
);
    import video_pkg::*;

    // one line, counted from the start of the back porch
    //
    //   back     visible          front  sync
    // :------>:------------------>:---->:---->:
    // ____________________________________
    //                                     |_____ hsync

    localparam int h_sync_start = h_back + h_visible + h_front;
    localparam int h_total      = h_sync_start + h_sync;
    localparam int v_sync_start = v_back + v_visible + v_front;
    localparam int v_total      = v_sync_start + v_sync;

    logic h_active;
    logic v_active;

    always_ff @(posedge clk_pixel) begin
        if (!nreset) begin
            h_pos <= '0;
            v_pos <= '0;
        end else if (h_pos == pos_t'(h_total - 1)) begin
            h_pos <= '0;
            if (v_pos == pos_t'(v_total - 1)) begin
                v_pos <= '0;
            end else begin
                v_pos <= v_pos + 1'b1;
            end
        end else begin
            h_pos <= h_pos + 1'b1;
        end
    end

    // all decodes come off the same counts
    assign h_active = (h_pos >= pos_t'(h_back)) && (h_pos < pos_t'(h_back + h_visible));
    assign v_active = (v_pos >= pos_t'(v_back)) && (v_pos < pos_t'(v_back + v_visible));

    assign visible_raw = h_active && v_active;
    // syncs are active low
    assign hsync_raw = (h_pos < pos_t'(h_sync_start));
    assign vsync_raw = (v_pos < pos_t'(v_sync_start));

endmodule

`default_nettype wire

//--- logic/pixel_fetch.sv
`default_nettype none
`timescale 1ns/100ps

module pixel_fetch (
    input  logic                  clk_pixel,
    input  logic                  nreset,
    input  video_pkg::pos_t       h_pos,
    input  video_pkg::pos_t       v_pos,
    input  video_pkg::addr_t      base_addr,
    input  video_pkg::pos_t       vp_left,
    input  video_pkg::pos_t       vp_right,
    input  video_pkg::pos_t       vp_top,
    input  video_pkg::pos_t       vp_bottom,
    input  video_pkg::mode_t      mode,
    input  logic [7:0]            mem_din,
    output logic                  mem_rd,
    output video_pkg::addr_t      mem_addr,
    output video_pkg::pix_index_t pix_index,
    output logic                  pix_in_view
);
    import video_pkg::*;

    logic       in_view;
    logic       restart;
    logic [2:0] bpp;
    logic [2:0] last_sub;
    logic [2:0] sub;
    logic [2:0] eff_sub;
    addr_t      next_addr;
    logic       rd_d1;
    logic       view_d1;
    logic [7:0] pixels;

    // --------------------------------------------------
    // mode decode
    // --------------------------------------------------

    always_comb begin
        case (mode)
            mode_2bpp: begin
                bpp      = 3'd2;
                last_sub = 3'd3;
            end
            mode_4bpp: begin
                bpp      = 3'd4;
                last_sub = 3'd1;
            end
            default: begin
                bpp      = 3'd1;
                last_sub = 3'd7;
            end
        endcase
    end

    // --------------------------------------------------
    // viewport and addressing
    // --------------------------------------------------

    assign in_view = (h_pos >= vp_left) && (h_pos < vp_right)
                  && (v_pos >= vp_top) && (v_pos < vp_bottom);

    // first pixel of the frame restarts at the base address
    assign restart = (v_pos == vp_top) && (h_pos == vp_left);
    assign eff_sub = restart ? 3'd0 : sub;

    // a new byte is needed at the first pixel of each group
    assign mem_rd   = in_view && (eff_sub == 3'd0);
    assign mem_addr = restart ? base_addr : next_addr;

    // sub keeps running across lines, so a line may start mid byte
    always_ff @(posedge clk_pixel) begin
        if (!nreset) begin
            sub       <= '0;
            next_addr <= '0;
        end else if (in_view) begin
            if (eff_sub == last_sub) begin
                sub <= '0;
            end else begin
                sub <= eff_sub + 1'b1;
            end
            if (mem_rd) begin
                next_addr <= mem_addr + 1'b1;
            end
        end
    end

    // --------------------------------------------------
    // shift register, two cycles behind the counters
    // --------------------------------------------------

    always_ff @(posedge clk_pixel) begin
        if (!nreset) begin
            rd_d1       <= 1'b0;
            view_d1     <= 1'b0;
            pix_in_view <= 1'b0;
        end else begin
            rd_d1       <= mem_rd;
            view_d1     <= in_view;
            pix_in_view <= view_d1;
        end
    end

    // memory data lands one cycle after the read
    always_ff @(posedge clk_pixel) begin
        if (rd_d1) begin
            pixels <= mem_din;
        end else if (view_d1) begin
            pixels <= pixels << bpp;
        end
    end

    // leftmost pixel sits in the top bits
    always_comb begin
        case (mode)
            mode_2bpp: pix_index = {2'b0, pixels[7:6]};
            mode_4bpp: pix_index = pixels[7:4];
            default:   pix_index = {3'b0, pixels[7]};
        endcase
    end

endmodule

`default_nettype wire

//--- logic/palette_out.sv
`default_nettype none
`timescale 1ns/100ps

module palette_out (
    input  logic                  clk_pixel,
    input  logic                  nreset,
    input  logic                  hsync_raw,
    input  logic                  vsync_raw,
    input  logic                  visible_raw,
    input  video_pkg::pix_index_t pix_index,
    input  logic                  pix_in_view,
    input  video_pkg::rgb444_t    palette_data,
    input  video_pkg::rgb444_t    border,
    output video_pkg::pix_index_t palette_addr,
    output logic                  hsync,
    output logic                  vsync,
    output logic                  blank,
    output video_pkg::rgb888_t    rgb
);
    import video_pkg::*;

    logic [pixel_latency-1:0] hs_dly;
    logic [pixel_latency-1:0] vs_dly;
    logic [pixel_latency-1:0] vis_dly;
    rgb444_t                  colour;

    assign palette_addr = pix_index;

    // border outside the viewport
    assign colour = pix_in_view ? palette_data : border;

    always_ff @(posedge clk_pixel) begin
        if (!nreset) begin
            hs_dly  <= '1;
            vs_dly  <= '1;
            vis_dly <= '0;
            hsync   <= 1'b1;
            vsync   <= 1'b1;
            blank   <= 1'b1;
            rgb     <= '0;
        end else begin
            // match the fetch pipeline
            hs_dly  <= {hs_dly[pixel_latency-2:0], hsync_raw};
            vs_dly  <= {vs_dly[pixel_latency-2:0], vsync_raw};
            vis_dly <= {vis_dly[pixel_latency-2:0], visible_raw};
            hsync   <= hs_dly[pixel_latency-1];
            vsync   <= vs_dly[pixel_latency-1];
            blank   <= !vis_dly[pixel_latency-1];
            // replicate each nibble to span the full 8-bit range
            if (vis_dly[pixel_latency-1]) begin
                rgb <= {colour[11:8], colour[11:8], colour[7:4], colour[7:4],
                        colour[3:0], colour[3:0]};
            end else begin
                rgb <= '0;
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/video_ctl.sv
`default_nettype none
`timescale 1ns/100ps

module video_ctl #(
    parameter int h_back    = 44,
    parameter int h_visible = 640,
    parameter int h_front   = 16,
    parameter int h_sync    = 96,
    parameter int v_back    = 31,
    parameter int v_visible = 480,
    parameter int v_front   = 10,
    parameter int v_sync    = 2
) (
    input  logic                 clk_pixel,
    input  logic                 nreset,
    // apb slave
    input  logic                 psel,
    input  logic                 penable,
    input  logic                 pwrite,
    input  video_pkg::reg_addr_t paddr,
    input  video_pkg::word_t     pwdata,
    output video_pkg::word_t     prdata,
    output logic                 pready,
    output logic                 pslverr,
    // vga out
    output logic                 hsync,
    output logic                 vsync,
    output logic                 blank,
    output video_pkg::rgb888_t   rgb,
    // video memory
    output video_pkg::addr_t     mem_addr,
    output logic                 mem_rd,
    input  logic [7:0]           mem_din
);
    import video_pkg::*;

    addr_t      base_addr;
    pos_t       vp_left;
    pos_t       vp_right;
    pos_t       vp_top;
    pos_t       vp_bottom;
    mode_t      mode;
    rgb444_t    border;
    pix_index_t palette_addr;
    rgb444_t    palette_data;
    pos_t       h_pos;
    pos_t       v_pos;
    logic       hsync_raw;
    logic       vsync_raw;
    logic       visible_raw;
    pix_index_t pix_index;
    logic       pix_in_view;

    video_regs i_video_regs (
        .clk_pixel(clk_pixel), .nreset(nreset),
        .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata), .palette_addr(palette_addr),
        .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .base_addr(base_addr), .vp_left(vp_left), .vp_right(vp_right),
        .vp_top(vp_top), .vp_bottom(vp_bottom), .mode(mode),
        .border(border), .palette_data(palette_data)
    );

    raster_timing #(
        .h_back(h_back), .h_visible(h_visible), .h_front(h_front), .h_sync(h_sync),
        .v_back(v_back), .v_visible(v_visible), .v_front(v_front), .v_sync(v_sync)
    ) i_raster_timing (
        .clk_pixel(clk_pixel), .nreset(nreset),
        .h_pos(h_pos), .v_pos(v_pos),
        .hsync_raw(hsync_raw), .vsync_raw(vsync_raw), .visible_raw(visible_raw)
    );

    pixel_fetch i_pixel_fetch (
        .clk_pixel(clk_pixel), .nreset(nreset),
        .h_pos(h_pos), .v_pos(v_pos), .base_addr(base_addr),
        .vp_left(vp_left), .vp_right(vp_right), .vp_top(vp_top), .vp_bottom(vp_bottom),
        .mode(mode), .mem_din(mem_din), .mem_rd(mem_rd), .mem_addr(mem_addr),
        .pix_index(pix_index), .pix_in_view(pix_in_view)
    );

    palette_out i_palette_out (
        .clk_pixel(clk_pixel), .nreset(nreset),
        .hsync_raw(hsync_raw), .vsync_raw(vsync_raw), .visible_raw(visible_raw),
        .pix_index(pix_index), .pix_in_view(pix_in_view),
        .palette_data(palette_data), .border(border), .palette_addr(palette_addr),
        .hsync(hsync), .vsync(vsync), .blank(blank), .rgb(rgb)
    );

endmodule

`default_nettype wire

//--- bench/video_ctl_assertions.sv
`default_nettype none
`timescale 1ns/100ps

module video_ctl_assertions #(
    parameter int h_sync = 96
) (
    input logic               clk_pixel,
    input logic               nreset,
    input logic               hsync,
    input logic               blank,
    input video_pkg::rgb888_t rgb,
    input logic               mem_rd,
    input video_pkg::pos_t    v_pos,
    input video_pkg::pos_t    vp_top,
    input video_pkg::pos_t    vp_bottom
);
    int   low_count;
    logic hsync_bad = 1'b0;
    logic blank_bad = 1'b0;
    logic rd_bad = 1'b0;
    logic failed;

    // length of the current hsync low run
    always_ff @(posedge clk_pixel) begin
        if (!nreset) begin
            low_count <= 0;
        end else if (!hsync) begin
            low_count <= low_count + 1;
        end else begin
            low_count <= 0;
        end
    end

    hsync_width: assert property (@(posedge clk_pixel) disable iff (!nreset)
        $rose(hsync) |-> (low_count == h_sync))
        else begin
            $error("hsync low pulse of %0d cycles", low_count);
            hsync_bad = 1'b1;
        end

    blank_black: assert property (@(posedge clk_pixel) disable iff (!nreset)
        blank |-> (rgb == '0))
        else begin
            $error("rgb %h while blank is high", rgb);
            blank_bad = 1'b1;
        end

    // reads only happen on viewport lines
    read_in_lines: assert property (@(posedge clk_pixel) disable iff (!nreset)
        mem_rd |-> ((v_pos >= vp_top) && (v_pos < vp_bottom)))
        else begin
            $error("mem_rd on line %0d outside the viewport lines", v_pos);
            rd_bad = 1'b1;
        end

    assign failed = hsync_bad || blank_bad || rd_bad;

endmodule

bind video_ctl video_ctl_assertions #(
    .h_sync(h_sync)
) i_video_ctl_assertions (
    .clk_pixel(clk_pixel), .nreset(nreset), .hsync(hsync), .blank(blank), .rgb(rgb),
    .mem_rd(mem_rd), .v_pos(v_pos), .vp_top(vp_top), .vp_bottom(vp_bottom)
);

`default_nettype wire

//--- bench/video_ctl_tb.sv
`default_nettype none
`timescale 1ns/100ps

module video_ctl_tb;
    import video_pkg::*;

    localparam int h_back     = 4;
    localparam int h_visible  = 32;
    localparam int h_front    = 2;
    localparam int h_sync     = 4;
    localparam int v_back     = 2;
    localparam int v_visible  = 6;
    localparam int v_front    = 1;
    localparam int v_sync     = 2;
    localparam int line_len   = h_back + h_visible + h_front + h_sync;
    localparam int frame_len  = line_len * (v_back + v_visible + v_front + v_sync);
    localparam int clk_period = 8;
    // five captures of up to two frames each, plus apb traffic
    localparam int test_frames = 12;
    localparam int watchdog_ns = 2 * test_frames * frame_len * clk_period;

    logic       clk_pixel;
    logic       nreset;
    logic       psel;
    logic       penable;
    logic       pwrite;
    reg_addr_t  paddr;
    word_t      pwdata;
    word_t      prdata;
    logic       pready;
    logic       pslverr;
    logic       hsync;
    logic       vsync;
    logic       blank;
    rgb888_t    rgb;
    addr_t      mem_addr;
    logic       mem_rd;
    logic [7:0] mem_din = 8'h00;

    logic [7:0] mem [65536];

    // model copy of what was programmed
    addr_t   exp_base;
    pos_t    exp_left;
    pos_t    exp_right;
    pos_t    exp_top;
    pos_t    exp_bottom;
    mode_t   exp_mode;
    rgb444_t exp_border;
    rgb444_t exp_palette [16];

    // one frame, sample 0 at the vsync falling edge
    logic    cap_hsync [frame_len];
    logic    cap_vsync [frame_len];
    logic    cap_blank [frame_len];
    rgb888_t cap_rgb [frame_len];

    video_ctl #(
        .h_back(h_back), .h_visible(h_visible), .h_front(h_front), .h_sync(h_sync),
        .v_back(v_back), .v_visible(v_visible), .v_front(v_front), .v_sync(v_sync)
    ) i_video_ctl (
        .clk_pixel(clk_pixel), .nreset(nreset),
        .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
        .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .hsync(hsync), .vsync(vsync), .blank(blank), .rgb(rgb),
        .mem_addr(mem_addr), .mem_rd(mem_rd), .mem_din(mem_din)
    );

    initial begin
        clk_pixel = 1'b0;
        forever #(clk_period / 2) clk_pixel = ~clk_pixel;
    end

    // video memory, data one cycle after the read
    always @(posedge clk_pixel) begin
        if (mem_rd) begin
            mem_din <= mem[mem_addr];
        end
    end

    initial begin
        #(watchdog_ns);
        abort_run("watchdog expired before the tests finished");
    end

    always @(negedge clk_pixel) begin
        assert (!i_video_ctl.i_video_ctl_assertions.failed) else begin
            abort_run("a bound assertion on the DUT failed");
        end
    end

    // --------------------------------------------------
    // reporting and helpers
    // --------------------------------------------------

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_value(input string test, input string what,
                               input logic [31:0] expected, input logic [31:0] actual);
        assert (actual == expected) else begin
            abort_run($sformatf("CHECK FAILED %s: %s expected %0h actual %0h",
                                test, what, expected, actual));
        end
    endtask

    // a 4-bit level times 17 spans 0 to 255
    function automatic rgb888_t expand_colour(input rgb444_t c);
        rgb888_t x;
        x[23:16] = 8'(c[11:8]) * 8'd17;
        x[15:8]  = 8'(c[7:4]) * 8'd17;
        x[7:0]   = 8'(c[3:0]) * 8'd17;
        return x;
    endfunction

    // implemented bits of each register word
    function automatic word_t field_mask(input reg_addr_t addr);
        if (addr == ctl_base) begin
            return 16'hffff;
        end else if (addr == ctl_mode) begin
            return 16'h0003;
        end else if ((addr == ctl_border) || (addr >= palette_first)) begin
            return 16'h0fff;
        end
        return 16'h03ff;
    endfunction

    // 7 control words, then 16 palette words
    function automatic reg_addr_t mapped_addr(input int i);
        if (i < 7) begin
            return reg_addr_t'(i);
        end
        return palette_first + reg_addr_t'(i - 7);
    endfunction

    // --------------------------------------------------
    // apb driver
    // --------------------------------------------------

    task automatic apb_access(input logic write, input reg_addr_t addr, input word_t wdata,
                              output word_t rdata, output logic err);
        @(posedge clk_pixel);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= write;
        paddr   <= addr;
        pwdata  <= wdata;
        @(posedge clk_pixel);
        penable <= 1'b1;
        @(negedge clk_pixel);
        rdata = prdata;
        err   = pslverr;
        check_value("apb", "pready", 32'd1, 32'(pready));
        @(posedge clk_pixel);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic write_reg(input reg_addr_t addr, input word_t data);
        word_t rdata;
        logic  err;
        apb_access(1'b1, addr, data, rdata, err);
        check_value("register write", "pslverr", 32'd0, 32'(err));
    endtask

    task automatic program_palette();
        rgb444_t c;
        for (int i = 0; i < 16; i++) begin
            c = rgb444_t'($urandom);
            write_reg(palette_first + reg_addr_t'(i), {4'h0, c});
            exp_palette[i] = c;
        end
    endtask

    task automatic program_view(input addr_t base, input pos_t left, input pos_t right,
                                input pos_t top, input pos_t bottom, input mode_t mode,
                                input rgb444_t border);
        write_reg(ctl_base, base);
        write_reg(ctl_left, {6'h00, left});
        write_reg(ctl_right, {6'h00, right});
        write_reg(ctl_top, {6'h00, top});
        write_reg(ctl_bottom, {6'h00, bottom});
        write_reg(ctl_mode, {14'h0000, mode});
        write_reg(ctl_border, {4'h0, border});
        exp_base   = base;
        exp_left   = left;
        exp_right  = right;
        exp_top    = top;
        exp_bottom = bottom;
        exp_mode   = mode;
        exp_border = border;
    endtask

    // --------------------------------------------------
    // frame capture and reference frame
    // --------------------------------------------------

    task automatic capture_frame();
        logic prev_vsync;
        int   waited;
        waited = 0;
        @(negedge clk_pixel);
        prev_vsync = vsync;
        @(negedge clk_pixel);
        while (!(prev_vsync && !vsync)) begin
            waited++;
            if (waited > 2 * frame_len) begin
                abort_run("no vsync falling edge seen while waiting for a frame");
            end
            prev_vsync = vsync;
            @(negedge clk_pixel);
        end
        for (int i = 0; i < frame_len; i++) begin
            if (i > 0) begin
                @(negedge clk_pixel);
            end
            cap_hsync[i] = hsync;
            cap_vsync[i] = vsync;
            cap_blank[i] = blank;
            cap_rgb[i]   = rgb;
        end
    endtask

    task automatic compare_frame(input string test);
        int         p;
        int         h;
        int         v;
        int         n;
        int         bpp;
        int         per;
        logic       visible;
        logic       in_view;
        logic [7:0] pix_byte;
        logic [3:0] idx;
        rgb444_t    colour;
        rgb888_t    exp_rgb;
        string      where;
        bpp = (exp_mode == mode_2bpp) ? 2 : ((exp_mode == mode_4bpp) ? 4 : 1);
        per = 8 / bpp;
        n   = 0;
        for (int i = 0; i < frame_len; i++) begin
            // sample 0 is the first vsync line
            p = (line_len * (v_back + v_visible + v_front) + i) % frame_len;
            h = p % line_len;
            v = p / line_len;
            where = $sformatf("line %0d pixel %0d", v, h);
            visible = (h >= h_back) && (h < h_back + h_visible)
                   && (v >= v_back) && (v < v_back + v_visible);
            in_view = (h >= int'(exp_left)) && (h < int'(exp_right))
                   && (v >= int'(exp_top)) && (v < int'(exp_bottom));
            if (in_view) begin
                pix_byte = mem[16'(int'(exp_base) + n / per)];
                idx      = 4'((pix_byte >> (8 - bpp * (n % per + 1))) & ((1 << bpp) - 1));
                colour   = exp_palette[idx];
                n++;
            end else begin
                colour = exp_border;
            end
            exp_rgb = visible ? expand_colour(colour) : 24'h000000;
            check_value(test, {"hsync at ", where},
                        32'(h < line_len - h_sync), 32'(cap_hsync[i]));
            check_value(test, {"vsync at ", where},
                        32'(v < v_back + v_visible + v_front), 32'(cap_vsync[i]));
            check_value(test, {"blank at ", where}, 32'(!visible), 32'(cap_blank[i]));
            check_value(test, {"rgb at ", where}, 32'(exp_rgb), 32'(cap_rgb[i]));
        end
    endtask

    // --------------------------------------------------
    // directed tests
    // --------------------------------------------------

    task automatic test_apb();
        word_t     written [23];
        word_t     rdata;
        logic      err;
        reg_addr_t addr;
        for (int i = 0; i < 23; i++) begin
            written[i] = word_t'($urandom);
            write_reg(mapped_addr(i), written[i]);
        end
        for (int i = 0; i < 23; i++) begin
            addr = mapped_addr(i);
            apb_access(1'b0, addr, 16'h0000, rdata, err);
            check_value("apb", $sformatf("read of %0h", addr),
                        32'(written[i] & field_mask(addr)), 32'(rdata));
            check_value("apb", "pslverr on mapped read", 32'd0, 32'(err));
        end
        // unmapped words, one below and one above the palette
        apb_access(1'b1, 6'h0b, word_t'($urandom), rdata, err);
        check_value("apb", "pslverr on write to 0b", 32'd1, 32'(err));
        apb_access(1'b1, 6'h2c, word_t'($urandom), rdata, err);
        check_value("apb", "pslverr on write to 2c", 32'd1, 32'(err));
        apb_access(1'b0, 6'h2c, 16'h0000, rdata, err);
        check_value("apb", "pslverr on read of 2c", 32'd1, 32'(err));
        for (int i = 0; i < 23; i++) begin
            addr = mapped_addr(i);
            apb_access(1'b0, addr, 16'h0000, rdata, err);
            check_value("apb", $sformatf("read of %0h after unmapped writes", addr),
                        32'(written[i] & field_mask(addr)), 32'(rdata));
        end
    endtask

    task automatic test_sync();
        int last_fall;
        int low_run;
        int blank_run;
        int blank_lines;
        capture_frame();
        last_fall = -1;
        for (int i = 1; i < frame_len; i++) begin
            if (cap_hsync[i - 1] && !cap_hsync[i]) begin
                if (last_fall >= 0) begin
                    check_value("sync", "hsync period", line_len, i - last_fall);
                end
                last_fall = i;
                low_run   = 0;
                while ((i + low_run < frame_len) && !cap_hsync[i + low_run]) begin
                    low_run++;
                end
                check_value("sync", "hsync low cycles", h_sync, low_run);
            end
        end
        low_run = 0;
        while ((low_run < frame_len) && !cap_vsync[low_run]) begin
            low_run++;
        end
        check_value("sync", "vsync low cycles", v_sync * line_len, low_run);
        // blank per line, either whole line or the porches and sync
        blank_lines = 0;
        for (int l = 0; l < frame_len / line_len; l++) begin
            blank_run = 0;
            for (int k = 0; k < line_len; k++) begin
                if (cap_blank[l * line_len + k]) begin
                    blank_run++;
                end
            end
            if (blank_run == line_len) begin
                blank_lines++;
            end else begin
                check_value("sync", "blank cycles in a line", line_len - h_visible, blank_run);
            end
        end
        check_value("sync", "blanked lines", v_back + v_front + v_sync, blank_lines);
    endtask

    task automatic test_border();
        program_view(addr_t'($urandom), 10'd10, 10'd10, pos_t'(v_back),
                     pos_t'(v_back + v_visible), mode_1bpp, rgb444_t'($urandom));
        capture_frame();
        compare_frame("border");
    endtask

    task automatic test_bitmap(input string test, input mode_t mode);
        int left;
        int right;
        int top;
        int bottom;
        left   = h_back + int'($urandom % 6);
        right  = left + 8 + int'($urandom % (h_back + h_visible - left - 7));
        top    = v_back + int'($urandom % 2);
        bottom = top + 2 + int'($urandom % (v_back + v_visible - top - 1));
        program_palette();
        program_view(addr_t'($urandom), pos_t'(left), pos_t'(right), pos_t'(top),
                     pos_t'(bottom), mode, rgb444_t'($urandom));
        capture_frame();
        compare_frame(test);
    endtask

    // --------------------------------------------------
    // main sequence
    // --------------------------------------------------

    initial begin
        nreset  = 1'b0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        void'($urandom(32'hac5a_8b83));
        for (int i = 0; i < 65536; i++) begin
            mem[i] = 8'($urandom);
        end
        repeat (7) @(posedge clk_pixel);
        @(negedge clk_pixel);
        check_value("reset", "hsync", 32'd1, 32'(hsync));
        check_value("reset", "vsync", 32'd1, 32'(vsync));
        check_value("reset", "blank", 32'd1, 32'(blank));
        check_value("reset", "rgb", 32'd0, 32'(rgb));
        check_value("reset", "mem_rd", 32'd0, 32'(mem_rd));
        check_value("reset", "pready", 32'd0, 32'(pready));
        check_value("reset", "pslverr", 32'd0, 32'(pslverr));
        @(posedge clk_pixel);
        nreset <= 1'b1;

        test_apb();
        test_sync();
        test_border();
        test_bitmap("bitmap 1bpp", mode_1bpp);
        test_bitmap("bitmap 2bpp", mode_2bpp);
        test_bitmap("bitmap 4bpp", mode_4bpp);

        $display("Simulation passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- list.f
logic/video_pkg.sv
logic/video_regs.sv
logic/raster_timing.sv
logic/pixel_fetch.sv
logic/palette_out.sv
logic/video_ctl.sv
bench/video_ctl_assertions.sv
bench/video_ctl_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= video_ctl_tb
FILE_LIST ?= list.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
SIM_FLAGS ?= +verilator+error+limit+100

SOURCES := $(wildcard logic/*.sv bench/*.sv)

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILE_LIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) $(SIM_FLAGS)

clean:
	rm -rf $(BUILD_DIR)
